// ==== source/safe_domain_pkg.sv ====
package safe_domain_pkg;

	////////////////////////////////////////
	// Register map.
	////////////////////////////////////////
	typedef enum logic [5:0] {
		VOLT      = 6'h00,
		PMU_CTRL  = 6'h01,
		PAD_CFG0  = 6'h14,
		PAD_CFG1  = 6'h15,
		PAD_CFG2  = 6'h16,
		PAD_CFG3  = 6'h17,
		PAD_SLEEP = 6'h18,
		RTC_CLOCK = 6'h34,
		RTC_ALARM = 6'h35,
		RTC_DATE  = 6'h37
	} reg_addr_e;

	////////////////////////////////////////
	// Field types.
	////////////////////////////////////////
	typedef struct packed {
		logic [4:0] hours;
		logic [5:0] minutes;
		logic [5:0] seconds;
	} rtc_time_t;

	// The alarm enable sits at bit 31 of the bus word.
	typedef struct packed {
		logic      en;
		rtc_time_t tod;
	} rtc_alarm_t;

	typedef struct packed {
		logic [11:0] year;
		logic [3:0]  month;
		logic [4:0]  day;
	} rtc_date_t;

	typedef struct packed {
		logic [4:0] rv;
		logic [4:0] lv;
		logic [4:0] mv;
		logic [4:0] nv;
	} volt_cfg_t;

	typedef enum logic [1:0] {
		RISE = 2'b00,
		FALL = 2'b01,
		HIGH = 2'b10,
		LOW  = 2'b11
	} wake_type_e;

	typedef struct packed {
		logic [10:0] mem_ret_lo;
		logic        cluster_wake;
		logic [1:0]  reboot;
		logic        wake_event;
		logic        boot_l2;
		logic [1:0]  wakeup;
		logic        wake_en;
		wake_type_e  wake_type;
		logic [4:0]  wake_sel;
		logic [2:0]  reserved;
		logic        mem_ret_hi;
		logic [1:0]  fll_ret;
	} pmu_ctrl_t;

	typedef union packed {
		logic [31:0] raw;
		pmu_ctrl_t   f;
	} pmu_word_u;

	localparam volt_cfg_t VOLT_RESET = '{rv: 5'h05, lv: 5'h09, mv: 5'h09, nv: 5'h0d};

endpackage

// ==== source/sync_wedge.sv ====
`timescale 1ns/100ps

module sync_wedge (
	input  logic clk_i,
	input  logic rstn_i,
	input  logic serial_i,
	output logic rise_o,
	output logic fall_o,
	output logic serial_o
);

	// Two synchronizer stages, then one history stage.
	logic [2:0] stage_q;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			stage_q <= '0;
		end else begin
			stage_q <= {stage_q[1:0], serial_i};
		end
	end

	assign rise_o   = stage_q[1] & ~stage_q[2];
	assign fall_o   = ~stage_q[1] & stage_q[2];
	assign serial_o = stage_q[1];

endmodule

// ==== source/rtc_clock.sv ====
`timescale 1ns/100ps

module rtc_clock import safe_domain_pkg::*; #(
	parameter int unsigned PRESCALE = 32768
) (
	input  logic       clk_i,
	input  logic       rstn_i,
	input  logic       clock_upd_i,
	input  rtc_time_t  clock_i,
	input  logic       alarm_upd_i,
	input  rtc_alarm_t alarm_i,
	output rtc_time_t  clock_o,
	output rtc_alarm_t alarm_o,
	output logic       event_o,
	output logic       new_day_o
);

	localparam int unsigned CW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam logic [CW-1:0] PRE_LAST = CW'(PRESCALE - 1);

	logic [CW-1:0] pre_q;
	logic          tick;
	rtc_time_t     time_q;
	rtc_time_t     time_next;
	logic          day_wrap;
	rtc_alarm_t    alarm_q;
	logic          event_q;
	logic          new_day_q;

	////////////////////////////////////////
	// Seconds prescaler.
	////////////////////////////////////////
	assign tick = (pre_q == PRE_LAST);

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			pre_q <= '0;
		end else if (clock_upd_i || tick) begin
			pre_q <= '0;
		end else begin
			pre_q <= pre_q + 1'b1;
		end
	end

	// Cascaded seconds, minutes and hours.
	always_comb begin
		time_next = time_q;
		day_wrap  = 1'b0;
		if (time_q.seconds == 6'd59) begin
			time_next.seconds = '0;
			if (time_q.minutes == 6'd59) begin
				time_next.minutes = '0;
				if (time_q.hours == 5'd23) begin
					time_next.hours = '0;
					day_wrap        = 1'b1;
				end else begin
					time_next.hours = time_q.hours + 5'd1;
				end
			end else begin
				time_next.minutes = time_q.minutes + 6'd1;
			end
		end else begin
			time_next.seconds = time_q.seconds + 6'd1;
		end
	end

	////////////////////////////////////////
	// Time, alarm and event pulses.
	////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			time_q    <= '0;
			alarm_q   <= '0;
			event_q   <= 1'b0;
			new_day_q <= 1'b0;
		end else begin
			event_q   <= 1'b0;
			new_day_q <= 1'b0;
			if (clock_upd_i) begin
				time_q <= clock_i;
			end else if (tick) begin
				time_q    <= time_next;
				new_day_q <= day_wrap;
			end
			// One-shot alarm disarms itself when it fires.
			if (alarm_upd_i) begin
				alarm_q <= alarm_i;
			end else if (tick && !clock_upd_i && alarm_q.en && (time_next == alarm_q.tod)) begin
				alarm_q.en <= 1'b0;
				event_q    <= 1'b1;
			end
		end
	end

	assign clock_o   = time_q;
	assign alarm_o   = alarm_q;
	assign event_o   = event_q;
	assign new_day_o = new_day_q;

endmodule

// ==== source/rtc_date.sv ====
`timescale 1ns/100ps

module rtc_date import safe_domain_pkg::*; (
	input  logic      clk_i,
	input  logic      rstn_i,
	input  logic      date_upd_i,
	input  rtc_date_t date_i,
	input  logic      new_day_i,
	output rtc_date_t date_o
);

	rtc_date_t date_q;

	// Leap years are every fourth year.
	function automatic logic [4:0] month_days(input logic [3:0] month, input logic [11:0] year);
		logic [4:0] days;
		case (month)
			4'd2:                    days = (year[1:0] == 2'b00) ? 5'd29 : 5'd28;
			4'd4, 4'd6, 4'd9, 4'd11: days = 5'd30;
			default:                 days = 5'd31;
		endcase
		return days;
	endfunction

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			date_q <= '0;
		end else if (date_upd_i) begin
			date_q <= date_i;
		end else if (new_day_i) begin
			if (date_q.day >= month_days(date_q.month, date_q.year)) begin
				date_q.day <= 5'd1;
				if (date_q.month >= 4'd12) begin
					date_q.month <= 4'd1;
					date_q.year  <= date_q.year + 12'd1;
				end else begin
					date_q.month <= date_q.month + 4'd1;
				end
			end else begin
				date_q.day <= date_q.day + 5'd1;
			end
		end
	end

	assign date_o = date_q;

endmodule

// ==== source/ext_wakeup.sv ====
`timescale 1ns/100ps

module ext_wakeup import safe_domain_pkg::*; (
	input  logic        clk_i,
	input  logic        rstn_i,
	input  logic [31:0] gpio_i,
	input  logic [4:0]  sel_i,
	input  wake_type_e  type_i,
	input  logic        en_i,
	input  logic        clr_i,
	output logic        event_o
);

	logic [2:0] sync_q;
	logic       event_q;
	logic       hit;

	// Stage 1 is the settled level, stage 2 the previous one.
	always_comb begin
		case (type_i)
			RISE:    hit = sync_q[1] & ~sync_q[2];
			FALL:    hit = ~sync_q[1] & sync_q[2];
			HIGH:    hit = sync_q[1];
			default: hit = ~sync_q[1];
		endcase
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			sync_q  <= '0;
			event_q <= 1'b0;
		end else begin
			if (en_i) begin
				sync_q <= {sync_q[1:0], gpio_i[sel_i]};
			end
			// Sticky until cleared.
			if (clr_i) begin
				event_q <= 1'b0;
			end else if (en_i && hit) begin
				event_q <= 1'b1;
			end
		end
	end

	assign event_o = event_q;

endmodule

// ==== source/safe_domain_reg_if.sv ====
`timescale 1ns/100ps

module safe_domain_reg_if import safe_domain_pkg::*; (
	input  logic         clk_i,
	input  logic         rstn_i,
	input  logic         req_i,
	input  logic         wrn_i,
	input  reg_addr_e    addr_i,
	input  logic [31:0]  wdata_i,
	output logic         ack_o,
	output logic [31:0]  rdata_o,
	output logic         clock_upd_o,
	output logic         alarm_upd_o,
	output logic         date_upd_o,
	input  rtc_time_t    clock_i,
	input  rtc_alarm_t   alarm_i,
	input  rtc_date_t    date_i,
	input  logic         wake_event_i,
	output logic         wake_clr_o,
	output volt_cfg_t    volt_o,
	output pmu_word_u    pmu_o,
	output logic [127:0] pad_sleep_cfg_o,
	output logic         pad_sleep_mode_o
);

	logic             req_rise;
	logic             req_fall;
	logic             wr_stb;
	logic             rd_stb;
	logic             ack_q;
	logic             rd_pmu_q;
	pmu_word_u        wdata_pmu;
	volt_cfg_t        volt_q;
	pmu_ctrl_t        pmu_q;
	logic [3:0][31:0] pad_cfg_q;
	logic             pad_sleep_q;

	sync_wedge i_req_sync (
		.clk_i    (clk_i),
		.rstn_i   (rstn_i),
		.serial_i (req_i),
		.rise_o   (req_rise),
		.fall_o   (req_fall),
		.serial_o ()
	);

	assign wr_stb    = req_rise & ~wrn_i;
	assign rd_stb    = req_rise & wrn_i;
	assign wdata_pmu = wdata_i;

	////////////////////////////////////////
	// Handshake and strobes.
	////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			ack_q    <= 1'b0;
			rd_pmu_q <= 1'b0;
		end else begin
			if (req_rise) begin
				ack_q <= 1'b1;
			end else if (req_fall) begin
				ack_q <= 1'b0;
			end
			if (rd_stb && (addr_i == PMU_CTRL)) begin
				rd_pmu_q <= 1'b1;
			end else if (req_fall) begin
				rd_pmu_q <= 1'b0;
			end
		end
	end

	assign ack_o       = ack_q;
	assign clock_upd_o = wr_stb && (addr_i == RTC_CLOCK);
	assign alarm_upd_o = wr_stb && (addr_i == RTC_ALARM);
	assign date_upd_o  = wr_stb && (addr_i == RTC_DATE);
	// The event clears when the read ends, so the read itself still sees it.
	assign wake_clr_o  = req_fall & rd_pmu_q;

	////////////////////////////////////////
	// Configuration registers.
	////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			volt_q      <= VOLT_RESET;
			pmu_q       <= '0;
			pad_cfg_q   <= '0;
			pad_sleep_q <= 1'b0;
		end else if (wr_stb) begin
			case (addr_i)
				VOLT: begin
					volt_q.nv <= wdata_i[4:0];
					volt_q.mv <= wdata_i[12:8];
					volt_q.lv <= wdata_i[20:16];
					volt_q.rv <= wdata_i[28:24];
				end
				PMU_CTRL: begin
					pmu_q            <= wdata_pmu.f;
					pmu_q.reserved   <= '0;
					pmu_q.wake_event <= 1'b0;
				end
				PAD_CFG0, PAD_CFG1, PAD_CFG2, PAD_CFG3: pad_cfg_q[addr_i[1:0]] <= wdata_i;
				PAD_SLEEP: pad_sleep_q <= wdata_i[0];
				default: ;
			endcase
		end
	end

	// Live wake event replaces the stored bit.
	always_comb begin
		pmu_o              = pmu_q;
		pmu_o.f.wake_event = wake_event_i;
	end

	assign volt_o           = volt_q;
	assign pad_sleep_cfg_o  = pad_cfg_q;
	assign pad_sleep_mode_o = pad_sleep_q;

	// Read multiplexer.
	always_comb begin
		rdata_o = '0;
		case (addr_i)
			VOLT: rdata_o = {3'b0, volt_q.rv, 3'b0, volt_q.lv, 3'b0, volt_q.mv, 3'b0, volt_q.nv};
			PMU_CTRL: rdata_o = pmu_o.raw;
			PAD_CFG0, PAD_CFG1, PAD_CFG2, PAD_CFG3: rdata_o = pad_cfg_q[addr_i[1:0]];
			PAD_SLEEP: rdata_o = {31'b0, pad_sleep_q};
			RTC_CLOCK: rdata_o = {15'b0, clock_i};
			RTC_ALARM: rdata_o = {alarm_i.en, 14'b0, alarm_i.tod};
			RTC_DATE: rdata_o = {11'b0, date_i};
			default: rdata_o = '0;
		endcase
	end

endmodule

// ==== source/safe_domain_top.sv ====
`timescale 1ns/100ps

module safe_domain_top import safe_domain_pkg::*; #(
	parameter int unsigned PRESCALE = 32768
) (
	input  logic         clk_i,
	input  logic         rstn_i,
	input  logic         req_i,
	input  logic         wrn_i,
	input  reg_addr_e    addr_i,
	input  logic [31:0]  wdata_i,
	input  logic [31:0]  wake_gpio_i,
	output logic         ack_o,
	output logic [31:0]  rdata_o,
	output volt_cfg_t    volt_o,
	output pmu_word_u    pmu_o,
	output logic [127:0] pad_sleep_cfg_o,
	output logic         pad_sleep_mode_o,
	output logic         wake_event_o,
	output logic         rtc_event_o
);

	logic       clock_upd;
	logic       alarm_upd;
	logic       date_upd;
	logic       new_day;
	logic       wake_clr;
	rtc_time_t  rtc_time;
	rtc_alarm_t rtc_alarm;
	rtc_date_t  rtc_day;

	safe_domain_reg_if i_reg_if (
		.clk_i            (clk_i),
		.rstn_i           (rstn_i),
		.req_i            (req_i),
		.wrn_i            (wrn_i),
		.addr_i           (addr_i),
		.wdata_i          (wdata_i),
		.ack_o            (ack_o),
		.rdata_o          (rdata_o),
		.clock_upd_o      (clock_upd),
		.alarm_upd_o      (alarm_upd),
		.date_upd_o       (date_upd),
		.clock_i          (rtc_time),
		.alarm_i          (rtc_alarm),
		.date_i           (rtc_day),
		.wake_event_i     (wake_event_o),
		.wake_clr_o       (wake_clr),
		.volt_o           (volt_o),
		.pmu_o            (pmu_o),
		.pad_sleep_cfg_o  (pad_sleep_cfg_o),
		.pad_sleep_mode_o (pad_sleep_mode_o)
	);

	rtc_clock #(
		.PRESCALE (PRESCALE)
	) i_rtc_clock (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.clock_upd_i (clock_upd),
		.clock_i     (rtc_time_t'(wdata_i[16:0])),
		.alarm_upd_i (alarm_upd),
		.alarm_i     (rtc_alarm_t'({wdata_i[31], wdata_i[16:0]})),
		.clock_o     (rtc_time),
		.alarm_o     (rtc_alarm),
		.event_o     (rtc_event_o),
		.new_day_o   (new_day)
	);

	rtc_date i_rtc_date (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.date_upd_i (date_upd),
		.date_i     (rtc_date_t'(wdata_i[20:0])),
		.new_day_i  (new_day),
		.date_o     (rtc_day)
	);

	ext_wakeup i_ext_wakeup (
		.clk_i   (clk_i),
		.rstn_i  (rstn_i),
		.gpio_i  (wake_gpio_i),
		.sel_i   (pmu_o.f.wake_sel),
		.type_i  (pmu_o.f.wake_type),
		.en_i    (pmu_o.f.wake_en),
		.clr_i   (wake_clr),
		.event_o (wake_event_o)
	);

endmodule

// ==== dv/safe_domain_properties.sv ====
`timescale 1ns/100ps

module safe_domain_properties (
	input logic clk_i,
	input logic rstn_i,
	input logic req_i,
	input logic ack_o,
	input logic rtc_event_o
);

	////////////////////////////////////////
	// Handshake and event rules.
	////////////////////////////////////////
	ack_low_after_reset: assert property (@(posedge clk_i) $rose(rstn_i) |-> !ack_o)
		else $error("ack_o high right after reset");

	// Alarm event is a single-cycle pulse.
	rtc_event_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
		rtc_event_o |=> !rtc_event_o)
		else $error("rtc_event_o high for two cycles");

	ack_falls_after_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
		$fell(ack_o) |-> !req_i)
		else $error("ack_o fell while req_i high");

endmodule

bind safe_domain_top safe_domain_properties i_properties (
	.clk_i       (clk_i),
	.rstn_i      (rstn_i),
	.req_i       (req_i),
	.ack_o       (ack_o),
	.rtc_event_o (rtc_event_o)
);

// ==== dv/tb_safe_domain.sv ====
`timescale 1ns/100ps

module tb_safe_domain import safe_domain_pkg::*; ();

	localparam int unsigned PRESCALE     = 8;
	localparam int          ACK_TIMEOUT  = 16;
	localparam int          WAKE_TIMEOUT = 8;
	localparam int          POLL_LIMIT   = 32;

	logic         clk;
	logic         rstn;
	logic         req;
	logic         wrn;
	reg_addr_e    addr;
	logic [31:0]  wdata;
	logic [31:0]  wake_gpio;
	logic         ack;
	logic [31:0]  rdata;
	volt_cfg_t    volt;
	pmu_word_u    pmu;
	logic [127:0] pad_sleep_cfg;
	logic         pad_sleep_mode;
	logic         wake_event;
	logic         rtc_event;

	logic [31:0]  lfsr;
	int           mismatches;
	int           failures;

	safe_domain_top #(
		.PRESCALE (PRESCALE)
	) dut_i (
		.clk_i            (clk),
		.rstn_i           (rstn),
		.req_i            (req),
		.wrn_i            (wrn),
		.addr_i           (addr),
		.wdata_i          (wdata),
		.wake_gpio_i      (wake_gpio),
		.ack_o            (ack),
		.rdata_o          (rdata),
		.volt_o           (volt),
		.pmu_o            (pmu),
		.pad_sleep_cfg_o  (pad_sleep_cfg),
		.pad_sleep_mode_o (pad_sleep_mode),
		.wake_event_o     (wake_event),
		.rtc_event_o      (rtc_event)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers and bus tasks.
	////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 that steps once per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	task automatic settle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (ack !== level && cycles < ACK_TIMEOUT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (ack !== level) begin
			failures++;
			$display("handshake timeout: ack_o did not go to %0d", level);
		end
	endtask

	task automatic bus_write(input reg_addr_e a, input logic [31:0] d);
		@(posedge clk);
		#2;
		addr  = a;
		wdata = d;
		wrn   = 1'b0;
		req   = 1'b1;
		wait_ack(1'b1);
		req = 1'b0;
		wait_ack(1'b0);
		wrn = 1'b1;
	endtask

	task automatic bus_read(input reg_addr_e a, output logic [31:0] d);
		@(posedge clk);
		#2;
		addr = a;
		wrn  = 1'b1;
		req  = 1'b1;
		wait_ack(1'b1);
		d   = rdata;
		req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_time(input string name, input rtc_time_t got, input rtc_time_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_date(input string name, input rtc_date_t got, input rtc_date_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_volt(input string name, input volt_cfg_t got, input volt_cfg_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Directed tests.
	////////////////////////////////////////
	task automatic read_reset_values();
		logic [31:0] rd;
		bus_read(VOLT, rd);
		check_word("VOLT", rd, 32'h0509_090d);
		check_volt("volt_o", volt, VOLT_RESET);
		bus_read(PMU_CTRL, rd);
		check_word("PMU_CTRL", rd, '0);
		for (int k = 0; k < 4; k++) begin
			bus_read(reg_addr_e'(PAD_CFG0 + k), rd);
			check_word("PAD_CFG", rd, '0);
		end
		bus_read(PAD_SLEEP, rd);
		check_word("PAD_SLEEP", rd, '0);
	endtask

	task automatic register_readback();
		logic [31:0] d;
		logic [31:0] rd;
		logic [31:0] pad_words [4];
		volt_cfg_t   exp_volt;
		pmu_word_u   exp_pmu;
		d = rand_bits(32);
		bus_write(VOLT, d);
		bus_read(VOLT, rd);
		exp_volt = '{rv: d[28:24], lv: d[20:16], mv: d[12:8], nv: d[4:0]};
		check_word("VOLT", rd, d & 32'h1f1f_1f1f);
		check_volt("volt_o", volt, exp_volt);

		// Keep the wake detector off here.
		exp_pmu.raw       = rand_bits(32);
		exp_pmu.f.wake_en = 1'b0;
		bus_write(PMU_CTRL, exp_pmu.raw);
		exp_pmu.f.reserved   = '0;
		exp_pmu.f.wake_event = 1'b0;
		bus_read(PMU_CTRL, rd);
		check_word("PMU_CTRL", rd, exp_pmu.raw);
		check_word("pmu_o", pmu.raw, exp_pmu.raw);

		for (int k = 0; k < 4; k++) begin
			pad_words[k] = rand_bits(32);
			bus_write(reg_addr_e'(PAD_CFG0 + k), pad_words[k]);
		end
		for (int k = 0; k < 4; k++) begin
			bus_read(reg_addr_e'(PAD_CFG0 + k), rd);
			check_word("PAD_CFG", rd, pad_words[k]);
			check_word("pad_sleep_cfg_o", pad_sleep_cfg[32*k +: 32], pad_words[k]);
		end

		d = rand_bits(32);
		bus_write(PAD_SLEEP, d);
		bus_read(PAD_SLEEP, rd);
		check_word("PAD_SLEEP", rd, {31'b0, d[0]});
		check_word("pad_sleep_mode_o", {31'b0, pad_sleep_mode}, {31'b0, d[0]});

		bus_read(reg_addr_e'(6'h3f), rd);
		check_word("unused 0x3f", rd, '0);
		bus_read(reg_addr_e'(6'h02), rd);
		check_word("unused 0x02", rd, '0);
	endtask

	task automatic cross_midnight(input rtc_date_t start, input rtc_date_t exp);
		rtc_time_t   late;
		logic [31:0] rd;
		int          polls;
		late = '{hours: 5'd23, minutes: 6'd59, seconds: 6'd58};
		bus_write(RTC_DATE, {11'b0, start});
		bus_write(RTC_CLOCK, {15'b0, late});
		bus_read(RTC_CLOCK, rd);
		check_time("RTC_CLOCK", rd[16:0], late);
		polls = 0;
		while (rd[16:0] !== '0 && polls < POLL_LIMIT) begin
			bus_read(RTC_CLOCK, rd);
			polls++;
		end
		if (rd[16:0] !== '0) begin
			failures++;
			$display("RTC clock never reached 00:00:00");
		end
		bus_read(RTC_DATE, rd);
		check_date("RTC_DATE", rd[20:0], exp);
	endtask

	task automatic alarm_one_shot();
		rtc_time_t   start;
		rtc_time_t   at;
		logic [31:0] rd;
		int          cycles;
		int          extra;
		start   = '{hours: 5'd10, minutes: 6'd0, seconds: 6'd0};
		at      = start;
		at.seconds = 6'd3;
		bus_write(RTC_CLOCK, {15'b0, start});
		bus_write(RTC_ALARM, {1'b1, 14'b0, at});
		cycles = 0;
		while (rtc_event !== 1'b1 && cycles < 4 * PRESCALE) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (rtc_event !== 1'b1) begin
			failures++;
			$display("alarm did not fire within 4 seconds");
		end
		extra = 0;
		repeat (2 * PRESCALE) begin
			@(posedge clk);
			#2;
			if (rtc_event)
				extra++;
		end
		if (extra != 0) begin
			failures++;
			$display("one-shot alarm fired more than once");
		end
		bus_read(RTC_ALARM, rd);
		check_word("RTC_ALARM", rd, {1'b0, 14'b0, at});

		// Same alarm time, but disarmed.
		bus_write(RTC_CLOCK, {15'b0, start});
		bus_write(RTC_ALARM, {1'b0, 14'b0, at});
		extra = 0;
		repeat (5 * PRESCALE) begin
			@(posedge clk);
			#2;
			if (rtc_event)
				extra++;
		end
		if (extra != 0) begin
			failures++;
			$display("disabled alarm fired");
		end
	endtask

	task automatic wake_detect();
		wake_type_e  mode;
		logic [4:0]  sel;
		logic        idle;
		pmu_word_u   exp;
		logic [31:0] rd;
		int          cycles;
		for (int m = 0; m < 4; m++) begin
			mode = wake_type_e'(m);
			sel  = 5'(rand_bits(5));
			idle = (mode == RISE || mode == HIGH) ? 1'b0 : 1'b1;
			wake_gpio = {32{idle}};
			exp.raw         = '0;
			exp.f.wake_sel  = sel;
			exp.f.wake_type = mode;
			exp.f.wake_en   = 1'b1;
			bus_write(PMU_CTRL, exp.raw);
			settle(6);
			// Flush any event left from the previous setup.
			bus_read(PMU_CTRL, rd);
			if (wake_event !== 1'b0) begin
				failures++;
				$display("wake event set before the GPIO was driven");
			end
			wake_gpio[sel] = ~idle;
			cycles = 0;
			while (wake_event !== 1'b1 && cycles < WAKE_TIMEOUT) begin
				@(posedge clk);
				#2;
				cycles++;
			end
			if (wake_event !== 1'b1) begin
				failures++;
				$display("wake event not detected for mode %0d", m);
			end
			exp.f.wake_event = 1'b1;
			check_word("pmu_o", pmu.raw, exp.raw);
			wake_gpio[sel] = idle;
			settle(6);
			bus_read(PMU_CTRL, rd);
			check_word("PMU_CTRL", rd, exp.raw);
			check_word("wake_event_o", {31'b0, wake_event}, '0);
		end
	endtask

	task automatic wake_disabled();
		pmu_word_u   cfg;
		logic [4:0]  sel;
		logic [31:0] rd;
		int          hits;
		sel = 5'(rand_bits(5));
		wake_gpio = '0;
		cfg.raw        = '0;
		cfg.f.wake_sel = sel;
		bus_write(PMU_CTRL, cfg.raw);
		bus_read(PMU_CTRL, rd);
		hits = 0;
		repeat (8) begin
			wake_gpio[sel] = ~wake_gpio[sel];
			repeat (4) begin
				@(posedge clk);
				#2;
				if (wake_event)
					hits++;
			end
		end
		if (hits != 0) begin
			failures++;
			$display("wake event set while wake_en is clear");
		end
	endtask

	initial begin
		rstn       = 1'b0;
		req        = 1'b0;
		wrn        = 1'b1;
		addr       = VOLT;
		wdata      = '0;
		wake_gpio  = '0;
		lfsr       = 32'h8775;
		mismatches = 0;
		failures   = 0;
		repeat (16) @(posedge clk);
		#2;
		rstn = 1'b1;

		read_reset_values();
		register_readback();
		cross_midnight('{year: 12'd2023, month: 4'd12, day: 5'd31},
			'{year: 12'd2024, month: 4'd1, day: 5'd1});
		cross_midnight('{year: 12'd2024, month: 4'd2, day: 5'd28},
			'{year: 12'd2024, month: 4'd2, day: 5'd29});
		alarm_one_shot();
		wake_detect();
		wake_disabled();

		$display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
source/safe_domain_pkg.sv
source/sync_wedge.sv
source/rtc_clock.sv
source/rtc_date.sv
source/ext_wakeup.sv
source/safe_domain_reg_if.sv
source/safe_domain_top.sv
dv/safe_domain_properties.sv
dv/tb_safe_domain.sv

// ==== Bender.yml ====
package:
  name: safe_domain

sources:
  - source/safe_domain_pkg.sv
  - source/sync_wedge.sv
  - source/rtc_clock.sv
  - source/rtc_date.sv
  - source/ext_wakeup.sv
  - source/safe_domain_reg_if.sv
  - source/safe_domain_top.sv
  - target: test
    files:
      - dv/safe_domain_properties.sv
      - dv/tb_safe_domain.sv
